//--- Makefile
TOP := tbMipsCore

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee run.log
	@grep -q "^TEST OK$$" run.log

obj_dir/V$(TOP): mipsCore.f $(shell cat mipsCore.f)
	verilator --binary --timing -f mipsCore.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -f mipsCore.f --top-module $(TOP)
	verilator --lint-only -f mipsCore.f --top-module mipsCore

clean:
	rm -rf obj_dir run.log

//--- common/isaPkg.sv
`default_nettype none

package isaPkg;

    typedef logic [31:0] wordT;     // data or address word
    typedef logic [4:0]  regAddrT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;

    localparam regAddrT raReg = 5'd31;   // jal link target

    localparam opcodeT opRtype = 6'h00;
    localparam opcodeT opJ     = 6'h02;
    localparam opcodeT opJal   = 6'h03;
    localparam opcodeT opBeq   = 6'h04;
    localparam opcodeT opBne   = 6'h05;
    localparam opcodeT opAddiu = 6'h09;
    localparam opcodeT opSlti  = 6'h0a;
    localparam opcodeT opAndi  = 6'h0c;
    localparam opcodeT opOri   = 6'h0d;
    localparam opcodeT opLui   = 6'h0f;
    localparam opcodeT opLb    = 6'h20;
    localparam opcodeT opLw    = 6'h23;
    localparam opcodeT opLbu   = 6'h24;
    localparam opcodeT opSb    = 6'h28;
    localparam opcodeT opSw    = 6'h2b;

    localparam functT functSll  = 6'h00;   // all-zero word is the canonical nop
    localparam functT functAddu = 6'h21;
    localparam functT functSubu = 6'h23;
    localparam functT functAnd  = 6'h24;
    localparam functT functOr   = 6'h25;
    localparam functT functXor  = 6'h26;
    localparam functT functSlt  = 6'h2a;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr,
        aluXor, aluSlt, aluSll, aluLui
    } aluOpT;

endpackage

`default_nettype wire

//--- common/pipePkg.sv
`default_nettype none

package pipePkg;

    localparam isaPkg::wordT resetPc = 32'h0000_0000;

    typedef struct packed {
        logic            regWrite;
        isaPkg::regAddrT dest;
        logic            useImm;     // alu b from immediate
        isaPkg::aluOpT   aluOp;
        logic            memRead;
        logic            memWrite;
        logic            memByte;
        logic            memSigned;
        logic            branch;
        logic            isBne;
        logic            jump;
        logic            link;       // jal writes pc+8
    } ctrlT;

    typedef struct packed {
        logic            valid;
        isaPkg::wordT    pc;
        ctrlT            ctrl;
        isaPkg::regAddrT rs;
        isaPkg::regAddrT rt;
        logic [4:0]      shamt;
        isaPkg::wordT    rsData;
        isaPkg::wordT    rtData;
        isaPkg::wordT    imm;
    } idExT;

    typedef struct packed {
        logic         valid;
        isaPkg::wordT pc;
        ctrlT         ctrl;
        isaPkg::wordT result;     // alu result or link address
        isaPkg::wordT storeData;
    } exMemT;

    typedef struct packed {
        logic         valid;
        isaPkg::wordT pc;
        ctrlT         ctrl;
        isaPkg::wordT result;
    } memWbT;

    typedef enum logic [1:0] {regFile, fromMem, fromWb} fwdSelT;

    typedef struct packed {
        isaPkg::wordT addr;
        isaPkg::wordT wdata;
        logic         read;
        logic         write;
        logic         isByte;
        logic         isSigned;
    } memReqT;

endpackage

`default_nettype wire

//--- datapath/datapath.sv
`timescale 1ns/10ps
`default_nettype none

module datapath (
    input  wire                    clk,
    input  wire                    arstN,
    input  wire isaPkg::wordT      instr,
    input  wire isaPkg::wordT      loadData,
    output isaPkg::wordT           instAddr,
    output logic                   instEn,
    output pipePkg::memReqT        memReq,
    output isaPkg::wordT           wbPc,
    output logic                   wbWen,
    output isaPkg::regAddrT        wbNum,
    output isaPkg::wordT           wbData
);
    isaPkg::wordT    pcF;
    logic            fetchOn;
    logic            validD;
    isaPkg::wordT    pcD, instrD;
    isaPkg::regAddrT rsD, rtD;
    pipePkg::ctrlT   ctrlD;
    isaPkg::wordT    immD, rsDataD, rtDataD;
    pipePkg::idExT   idEx;
    pipePkg::exMemT  exMem;
    pipePkg::memWbT  memWb;
    pipePkg::fwdSelT fwdA, fwdB;
    logic            stallF, stallD, flushD, flushE;
    isaPkg::wordT    srcA, rtValE, aluB, aluOut;
    isaPkg::wordT    pcPlus4E, targetE, resultE, resultM;
    logic            takenE, redirect;

    function automatic isaPkg::wordT fwdMux(input pipePkg::fwdSelT sel,
                                            input isaPkg::wordT regVal);
        case (sel)
            pipePkg::fromMem: return exMem.result;
            pipePkg::fromWb:  return memWb.result;
            default:          return regVal;
        endcase
    endfunction

    assign instAddr = pcF;
    assign instEn   = fetchOn && !stallF;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fetchOn <= 1'b0;    // first fetch one cycle after reset
            pcF     <= pipePkg::resetPc;
        end else begin
            fetchOn <= 1'b1;
            if (redirect)
                pcF <= targetE;
            else if (instEn)
                pcF <= pcF + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validD <= 1'b0;
            pcD    <= '0;
            instrD <= '0;
        end else if (flushD) begin
            validD <= 1'b0;     // slot behind the delay slot
        end else if (!stallD) begin
            validD <= fetchOn;
            pcD    <= pcF;
            instrD <= instr;
        end
    end

    assign rsD = instrD[25:21];
    assign rtD = instrD[20:16];

    mainDecoder uDecoder (
        .instr (instrD),
        .ctrl  (ctrlD),
        .imm   (immD)
    );

    regFile uRegFile (
        .clk    (clk),
        .arstN  (arstN),
        .we     (wbWen),
        .wAddr  (wbNum),
        .wData  (wbData),
        .rAddrA (rsD),
        .rAddrB (rtD),
        .rDataA (rsDataD),
        .rDataB (rtDataD)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            idEx <= '0;
        else if (flushE)
            idEx <= '0;         // load-use bubble
        else
            idEx <= '{valid: validD, pc: pcD, ctrl: ctrlD, rs: rsD, rt: rtD,
                      shamt: instrD[10:6], rsData: rsDataD, rtData: rtDataD, imm: immD};
    end

    always_comb begin
        srcA   = fwdMux(fwdA, idEx.rsData);
        rtValE = fwdMux(fwdB, idEx.rtData);
    end

    assign aluB = idEx.ctrl.useImm ? idEx.imm : rtValE;

    alu uAlu (
        .op     (idEx.ctrl.aluOp),
        .a      (srcA),
        .b      (aluB),
        .shamt  (idEx.shamt),
        .result (aluOut)
    );

    // branch and jump resolve here, delay slot sits in decode
    assign pcPlus4E = idEx.pc + 32'd4;
    assign takenE   = idEx.ctrl.branch && ((srcA == rtValE) != idEx.ctrl.isBne);
    assign redirect = idEx.valid && (takenE || idEx.ctrl.jump);
    assign targetE  = idEx.ctrl.jump ? {pcPlus4E[31:28], idEx.imm[27:0]}
                                     : pcPlus4E + {idEx.imm[29:0], 2'b00};
    assign resultE  = idEx.ctrl.link ? idEx.pc + 32'd8 : aluOut;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            exMem <= '0;
        else
            exMem <= '{valid: idEx.valid, pc: idEx.pc, ctrl: idEx.ctrl,
                       result: resultE, storeData: rtValE};
    end

    assign memReq = '{addr: exMem.result, wdata: exMem.storeData,
                      read: exMem.valid && exMem.ctrl.memRead,
                      write: exMem.valid && exMem.ctrl.memWrite,
                      isByte: exMem.ctrl.memByte, isSigned: exMem.ctrl.memSigned};
    assign resultM = exMem.ctrl.memRead ? loadData : exMem.result;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            memWb <= '0;
        else
            memWb <= '{valid: exMem.valid, pc: exMem.pc, ctrl: exMem.ctrl, result: resultM};
    end

    assign wbPc   = memWb.pc;
    assign wbWen  = memWb.valid && memWb.ctrl.regWrite;
    assign wbNum  = memWb.ctrl.dest;
    assign wbData = memWb.result;

    hazardUnit uHazard (
        .idEx     (idEx),
        .exMem    (exMem),
        .memWb    (memWb),
        .rsD      (rsD),
        .rtD      (rtD),
        .redirect (redirect),
        .fwdA     (fwdA),
        .fwdB     (fwdB),
        .stallF   (stallF),
        .stallD   (stallD),
        .flushD   (flushD),
        .flushE   (flushE)
    );

endmodule

`default_nettype wire

//--- datapath/hazardUnit.sv
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
    input  wire pipePkg::idExT   idEx,
    input  wire pipePkg::exMemT  exMem,
    input  wire pipePkg::memWbT  memWb,
    input  wire isaPkg::regAddrT rsD,
    input  wire isaPkg::regAddrT rtD,
    input  wire                  redirect,
    output pipePkg::fwdSelT      fwdA,
    output pipePkg::fwdSelT      fwdB,
    output logic                 stallF,
    output logic                 stallD,
    output logic                 flushD,
    output logic                 flushE
);
    logic loadUse;

    function automatic pipePkg::fwdSelT pickFwd(input isaPkg::regAddrT src);
        if (src == '0)
            return pipePkg::regFile;
        if (exMem.valid && exMem.ctrl.regWrite && exMem.ctrl.dest == src)
            return pipePkg::fromMem;    // youngest writer first
        if (memWb.valid && memWb.ctrl.regWrite && memWb.ctrl.dest == src)
            return pipePkg::fromWb;
        return pipePkg::regFile;
    endfunction

    always_comb begin
        fwdA = pickFwd(idEx.rs);
        fwdB = pickFwd(idEx.rt);
    end

    // load data only exists from the memory stage on
    assign loadUse = idEx.valid && idEx.ctrl.memRead && idEx.ctrl.dest != '0
                     && (idEx.ctrl.dest == rsD || idEx.ctrl.dest == rtD);

    assign stallF = loadUse;
    assign stallD = loadUse;
    assign flushE = loadUse;            // bubble into execute
    assign flushD = redirect;           // drop fetch slot, delay slot goes on

    // a load in memory still carries its address as result
    always_comb begin
        if (idEx.valid && exMem.valid && exMem.ctrl.memRead)
            assert (fwdA != pipePkg::fromMem && fwdB != pipePkg::fromMem)
                else $error("load value forwarded before it left memory");
    end

endmodule

`default_nettype wire

//--- datapath/mainDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module mainDecoder (
    input  wire isaPkg::wordT instr,
    output pipePkg::ctrlT     ctrl,
    output isaPkg::wordT      imm
);
    isaPkg::opcodeT  opcode;
    isaPkg::functT   funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        ctrl        = '0;       // unknown encodings retire as a nop
        ctrl.dest   = instr[20:16];
        ctrl.useImm = 1'b1;
        imm         = {{16{instr[15]}}, instr[15:0]};
        case (opcode)
            isaPkg::opRtype: begin
                ctrl.useImm   = 1'b0;
                ctrl.dest     = instr[15:11];
                ctrl.regWrite = 1'b1;
                case (funct)
                    isaPkg::functSll:  ctrl.aluOp = isaPkg::aluSll;
                    isaPkg::functAddu: ctrl.aluOp = isaPkg::aluAdd;
                    isaPkg::functSubu: ctrl.aluOp = isaPkg::aluSub;
                    isaPkg::functAnd:  ctrl.aluOp = isaPkg::aluAnd;
                    isaPkg::functOr:   ctrl.aluOp = isaPkg::aluOr;
                    isaPkg::functXor:  ctrl.aluOp = isaPkg::aluXor;
                    isaPkg::functSlt:  ctrl.aluOp = isaPkg::aluSlt;
                    default:           ctrl.regWrite = 1'b0;
                endcase
            end
            isaPkg::opAddiu: ctrl.regWrite = 1'b1;
            isaPkg::opSlti: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = isaPkg::aluSlt;
            end
            isaPkg::opAndi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = isaPkg::aluAnd;
                imm           = {16'h0000, instr[15:0]};    // logical ops zero-extend
            end
            isaPkg::opOri: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = isaPkg::aluOr;
                imm           = {16'h0000, instr[15:0]};
            end
            isaPkg::opLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = isaPkg::aluLui;
            end
            isaPkg::opLw, isaPkg::opLb, isaPkg::opLbu: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memByte   = opcode != isaPkg::opLw;
                ctrl.memSigned = opcode == isaPkg::opLb;
            end
            isaPkg::opSw, isaPkg::opSb: begin
                ctrl.memWrite = 1'b1;
                ctrl.memByte  = opcode == isaPkg::opSb;
            end
            isaPkg::opBeq, isaPkg::opBne: begin
                ctrl.branch = 1'b1;     // compares rs with rt
                ctrl.isBne  = opcode == isaPkg::opBne;
            end
            isaPkg::opJ, isaPkg::opJal: begin
                ctrl.jump     = 1'b1;
                ctrl.link     = opcode == isaPkg::opJal;
                ctrl.regWrite = opcode == isaPkg::opJal;
                ctrl.dest     = isaPkg::raReg;
                imm           = {4'h0, instr[25:0], 2'b00};  // region offset of target
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- mipsCore.f
common/isaPkg.sv
common/pipePkg.sv
rtl/alu.sv
rtl/regFile.sv
rtl/memControl.sv
datapath/mainDecoder.sv
datapath/hazardUnit.sv
datapath/datapath.sv
rtl/mipsCore.sv
verification/clockGen.sv
verification/refChecker.sv
verification/tbMipsCore.sv

//--- rtl/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire isaPkg::aluOpT op,
    input  wire isaPkg::wordT  a,
    input  wire isaPkg::wordT  b,
    input  wire [4:0]          shamt,
    output isaPkg::wordT       result
);

    always_comb begin
        case (op)
            isaPkg::aluAdd: result = a + b;     // addu, addiu, address calc
            isaPkg::aluSub: result = a - b;
            isaPkg::aluAnd: result = a & b;
            isaPkg::aluOr:  result = a | b;
            isaPkg::aluXor: result = a ^ b;
            isaPkg::aluSlt: result = {31'b0, $signed(a) < $signed(b)};
            isaPkg::aluSll: result = b << shamt;            // shifts rt
            isaPkg::aluLui: result = {b[15:0], 16'h0000};
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/memControl.sv
`timescale 1ns/10ps
`default_nettype none

module memControl (
    input  wire pipePkg::memReqT memReq,
    input  wire isaPkg::wordT    memRdata,
    output logic                 memEn,
    output isaPkg::wordT         memAddr,
    output logic [3:0]           memWen,
    output isaPkg::wordT         memWdata,
    output isaPkg::wordT         loadData
);
    logic [1:0] lane;
    logic [7:0] loadByte;

    assign lane    = memReq.addr[1:0];
    assign memEn   = memReq.read || memReq.write;
    assign memAddr = memReq.addr;

    always_comb begin
        memWen = 4'b0000;
        if (memReq.write)
            memWen = memReq.isByte ? 4'b0001 << lane : 4'b1111;     // little-endian lanes
    end

    assign memWdata = memReq.isByte ? {4{memReq.wdata[7:0]}} : memReq.wdata;

    assign loadByte = memRdata[{lane, 3'b000} +: 8];

    always_comb begin
        if (!memReq.isByte)
            loadData = memRdata;
        else if (memReq.isSigned)
            loadData = {{24{loadByte[7]}}, loadByte};   // lb
        else
            loadData = {24'h000000, loadByte};          // lbu
    end

    always_comb begin
        if (memEn && !memReq.isByte)
            assert (lane == 2'b00)
                else $error("misaligned word access at %h", memReq.addr);
    end

endmodule

`default_nettype wire

//--- rtl/mipsCore.sv
`timescale 1ns/10ps
`default_nettype none

module mipsCore (
    input  wire                  clk,
    input  wire                  arstN,
    output isaPkg::wordT         instAddr,
    output logic                 instEn,
    input  wire isaPkg::wordT    instr,
    output logic                 memEn,
    output isaPkg::wordT         memAddr,
    output logic [3:0]           memWen,
    output isaPkg::wordT         memWdata,
    input  wire isaPkg::wordT    memRdata,
    output isaPkg::wordT         wbPc,
    output logic                 wbWen,
    output isaPkg::regAddrT      wbNum,
    output isaPkg::wordT         wbData
);
    pipePkg::memReqT memReq;    // memory-stage access
    isaPkg::wordT    loadData;

    datapath uDatapath (
        .clk      (clk),
        .arstN    (arstN),
        .instr    (instr),
        .loadData (loadData),
        .instAddr (instAddr),
        .instEn   (instEn),
        .memReq   (memReq),
        .wbPc     (wbPc),
        .wbWen    (wbWen),
        .wbNum    (wbNum),
        .wbData   (wbData)
    );

    memControl uMemControl (
        .memReq   (memReq),
        .memRdata (memRdata),
        .memEn    (memEn),
        .memAddr  (memAddr),
        .memWen   (memWen),
        .memWdata (memWdata),
        .loadData (loadData)
    );

endmodule

`default_nettype wire

//--- rtl/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  wire                  clk,
    input  wire                  arstN,
    input  wire                  we,
    input  wire isaPkg::regAddrT wAddr,
    input  wire isaPkg::wordT    wData,
    input  wire isaPkg::regAddrT rAddrA,
    input  wire isaPkg::regAddrT rAddrB,
    output isaPkg::wordT         rDataA,
    output isaPkg::wordT         rDataB
);
    isaPkg::wordT regs [32];

    function automatic isaPkg::wordT readPort(input isaPkg::regAddrT addr);
        if (addr == '0)
            return '0;
        if (we && addr == wAddr)
            return wData;               // write-before-read
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (we && wAddr != '0)
            regs[wAddr] <= wData;
    end

    always_comb begin
        rDataA = readPort(rAddrA);
        rDataB = readPort(rAddrB);
    end

    // a retired write to $0 must not show up on a later read
    assert property (@(posedge clk) disable iff (!arstN)
        (we && wAddr == '0) |=> (rAddrA != '0 || rDataA == '0)
                                && (rAddrB != '0 || rDataB == '0));

endmodule

`default_nettype wire

//--- verification/clockGen.sv
`timescale 1ns/10ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

    initial begin
        arstN = 1'b0;
        repeat (3) @(posedge clk);
        arstN <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/refChecker.sv
`timescale 1ns/10ps
`default_nettype none

module refChecker (
    input  wire                  clk,
    input  wire                  arstN,
    input  wire                  progReady,
    input  wire [31:0]           loopPc,
    input  logic [31:0]          prog [512],
    input  logic [31:0]          dmemInit [64],
    input  wire                  instEn,
    input  wire                  memEn,
    input  wire isaPkg::wordT    wbPc,
    input  wire                  wbWen,
    input  wire isaPkg::regAddrT wbNum,
    input  wire isaPkg::wordT    wbData,
    input  wire isaPkg::wordT    memAddr,
    input  wire [3:0]            memWen,
    input  wire isaPkg::wordT    memWdata,
    output logic                 done,
    output int                   valueErrors,
    output int                   otherErrors,
    output int                   pendingWb,
    output int                   pendingSt
);
    logic [31:0] mReg [32];
    logic [31:0] mMem [64];
    logic [31:0] expWbPc [$];
    logic [4:0]  expWbNum [$];
    logic [31:0] expWbData [$];
    logic [31:0] expStAddr [$];
    logic [3:0]  expStLanes [$];
    logic [31:0] expStData [$];
    logic        built = 1'b0;

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            valueErrors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // in-order model with one delay slot, records every register write and store
    task automatic runModel();
        logic [31:0]    pc, nextPc, newNext, ins, a, b, sImm, zImm, addr, res;
        isaPkg::opcodeT op;
        logic [1:0]     lane;
        logic [7:0]     byteVal;
        logic           wr;
        logic [4:0]     dest;
        int             steps;
        for (int i = 0; i < 32; i++)
            mReg[i] = '0;
        for (int i = 0; i < 64; i++)
            mMem[i] = dmemInit[i];
        pc = '0;
        nextPc = 32'd4;
        steps = 0;
        while (pc != loopPc && steps < 2000) begin
            ins = prog[pc[10:2]];
            op = ins[31:26];
            a = mReg[ins[25:21]];
            b = mReg[ins[20:16]];
            sImm = {{16{ins[15]}}, ins[15:0]};
            zImm = {16'h0000, ins[15:0]};
            addr = a + sImm;
            lane = addr[1:0];
            byteVal = mMem[addr[7:2]][{lane, 3'b000} +: 8];    // little-endian byte
            newNext = nextPc + 32'd4;
            wr = 1'b0;
            dest = ins[20:16];
            res = '0;
            case (op)
                isaPkg::opRtype: begin
                    wr = 1'b1;
                    dest = ins[15:11];
                    case (ins[5:0])
                        isaPkg::functAddu: res = a + b;
                        isaPkg::functSubu: res = a - b;
                        isaPkg::functAnd:  res = a & b;
                        isaPkg::functOr:   res = a | b;
                        isaPkg::functXor:  res = a ^ b;
                        isaPkg::functSlt:  res = {31'b0, $signed(a) < $signed(b)};
                        isaPkg::functSll:  res = b << ins[10:6];
                        default:           wr = 1'b0;
                    endcase
                end
                isaPkg::opAddiu: {wr, res} = {1'b1, a + sImm};
                isaPkg::opSlti:  {wr, res} = {1'b1, 31'b0, $signed(a) < $signed(sImm)};
                isaPkg::opAndi:  {wr, res} = {1'b1, a & zImm};
                isaPkg::opOri:   {wr, res} = {1'b1, a | zImm};
                isaPkg::opLui:   {wr, res} = {1'b1, ins[15:0], 16'h0000};
                isaPkg::opLw:    {wr, res} = {1'b1, mMem[addr[7:2]]};
                isaPkg::opLb:    {wr, res} = {1'b1, {24{byteVal[7]}}, byteVal};
                isaPkg::opLbu:   {wr, res} = {1'b1, 24'h000000, byteVal};
                isaPkg::opSw: begin
                    mMem[addr[7:2]] = b;
                    expStAddr.push_back(addr);
                    expStLanes.push_back(4'b1111);
                    expStData.push_back(b);
                end
                isaPkg::opSb: begin
                    mMem[addr[7:2]][{lane, 3'b000} +: 8] = b[7:0];
                    expStAddr.push_back(addr);
                    expStLanes.push_back(4'b0001 << lane);
                    expStData.push_back({4{b[7:0]}});
                end
                isaPkg::opBeq: if (a == b) newNext = pc + 32'd4 + (sImm << 2);
                isaPkg::opBne: if (a != b) newNext = pc + 32'd4 + (sImm << 2);
                isaPkg::opJ, isaPkg::opJal: begin
                    newNext = {nextPc[31:28], ins[25:0], 2'b00};
                    if (op == isaPkg::opJal) begin
                        wr = 1'b1;
                        dest = isaPkg::raReg;
                        res = pc + 32'd8;
                    end
                end
                default: ;
            endcase
            if (wr) begin
                expWbPc.push_back(pc);
                expWbNum.push_back(dest);
                expWbData.push_back(res);
                if (dest != 5'd0)
                    mReg[dest] = res;       // $0 stays zero
            end
            pc = nextPc;
            nextPc = newNext;
            steps++;
        end
        if (pc != loopPc) begin
            otherErrors++;
            $display("reference model never reached the final loop");
        end
    endtask

    always @(negedge clk) begin
        if (!built && progReady) begin
            valueErrors = 0;
            otherErrors = 0;
            runModel();
            built = 1'b1;
        end
        if (!arstN) begin
            if (wbWen !== 1'b0 || memWen !== 4'b0000 || instEn !== 1'b0
                || memEn !== 1'b0) begin
                otherErrors++;
                $display("fetch, memory or register write enable active during reset");
            end
        end else if (built) begin
            if ($isunknown({wbWen, memWen, instEn, memEn})) begin
                otherErrors++;
                $display("enable is unknown at %0t", $time);
            end else begin
                if (wbWen) begin
                    if (expWbPc.size() == 0) begin
                        otherErrors++;
                        $display("extra register write retired at pc %h", wbPc);
                    end else begin
                        checkValue("wbPc", wbPc, expWbPc.pop_front());
                        checkValue("wbNum", {27'b0, wbNum}, {27'b0, expWbNum.pop_front()});
                        checkValue("wbData", wbData, expWbData.pop_front());
                    end
                end
                if (memWen != 4'b0000) begin
                    if (expStAddr.size() == 0) begin
                        otherErrors++;
                        $display("extra store to address %h", memAddr);
                    end else begin
                        checkValue("memEn", {31'b0, memEn}, 32'd1);
                        checkValue("memAddr", memAddr, expStAddr.pop_front());
                        checkValue("memWen", {28'b0, memWen}, {28'b0, expStLanes.pop_front()});
                        checkValue("memWdata", memWdata, expStData.pop_front());
                    end
                end
            end
        end
        pendingWb = expWbPc.size();
        pendingSt = expStAddr.size();
        done = built && pendingWb == 0 && pendingSt == 0;
    end

endmodule

`default_nettype wire

//--- verification/tbMipsCore.sv
`timescale 1ns/10ps
`default_nettype none

module tbMipsCore;
    localparam int progLen   = 400;
    localparam int loopIdx   = progLen - 2;         // self-loop j, idle slot after it
    localparam int maxCycles = progLen * 4 + 100;

    logic            clk, arstN;
    logic            progReady = 1'b0;
    logic [31:0]     lfsr;
    logic [31:0]     imem [512];
    logic [31:0]     dmem [64];
    logic [31:0]     dmemInit [64];
    isaPkg::wordT    instAddr, instr, memAddr, memWdata, memRdata, wbPc, wbData;
    logic            instEn, memEn, wbWen, done;
    logic [3:0]      memWen;
    isaPkg::regAddrT wbNum;
    int              valueErrors, otherErrors, pendingWb, pendingSt;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic isaPkg::regAddrT regPick();
        return isaPkg::regAddrT'(randBits(3));     // few registers, many hazards
    endfunction

    function automatic logic [31:0] fillWord(input int idx);
        logic [31:0] addr;
        addr = 32'(idx) << 2;
        return (addr * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
    endfunction

    function automatic logic [31:0] rType(input isaPkg::regAddrT rs, rt, rd,
                                          input logic [4:0] shamt, input isaPkg::functT fn);
        return {isaPkg::opRtype, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] iType(input isaPkg::opcodeT op, input isaPkg::regAddrT rs,
                                          input isaPkg::regAddrT rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic genPlain(input int idx);
        logic [3:0]      kind;
        isaPkg::regAddrT rs, rt, rd;
        logic [15:0]     imm;
        kind = 4'(randBits(4));
        rs = regPick();
        rt = regPick();
        rd = regPick();
        imm = 16'(randBits(16));
        case (kind)
            4'd0:  imem[idx] = rType(rs, rt, rd, 5'd0, isaPkg::functAddu);
            4'd1:  imem[idx] = rType(rs, rt, rd, 5'd0, isaPkg::functSubu);
            4'd2:  imem[idx] = rType(rs, rt, rd, 5'd0, isaPkg::functAnd);
            4'd3:  imem[idx] = rType(rs, rt, rd, 5'd0, isaPkg::functOr);
            4'd4:  imem[idx] = rType(rs, rt, rd, 5'd0, isaPkg::functXor);
            4'd5:  imem[idx] = rType(rs, rt, rd, 5'd0, isaPkg::functSlt);
            4'd6:  imem[idx] = rType(5'd0, rt, rd, imm[4:0], isaPkg::functSll);
            4'd7:  imem[idx] = iType(isaPkg::opAddiu, rs, rt, imm);
            4'd8:  imem[idx] = iType(isaPkg::opAndi, rs, rt, imm);
            4'd9:  imem[idx] = iType(isaPkg::opOri, rs, rt, imm);
            4'd10: imem[idx] = iType(isaPkg::opSlti, rs, rt, imm);
            4'd11: imem[idx] = iType(isaPkg::opLui, 5'd0, rt, imm);
            4'd12: imem[idx] = iType(isaPkg::opLw, 5'd0, rt, {8'h00, imm[5:0], 2'b00});
            4'd13: imem[idx] = iType(imm[8] ? isaPkg::opLb : isaPkg::opLbu, 5'd0, rt,
                                     {8'h00, imm[7:0]});
            4'd14: imem[idx] = iType(isaPkg::opSw, 5'd0, rt, {8'h00, imm[5:0], 2'b00});
            default: imem[idx] = iType(isaPkg::opSb, 5'd0, rt, {8'h00, imm[7:0]});
        endcase
    endtask

    // forward targets only, never past the final loop
    task automatic genControl(input int idx);
        logic [1:0] kind;
        int         off, tgt;
        kind = 2'(randBits(2));
        if (kind < 2'd2) begin
            off = 1 + int'(randBits(3));
            if (idx + 1 + off > loopIdx)
                off = loopIdx - idx - 1;
            imem[idx] = iType(kind[0] ? isaPkg::opBne : isaPkg::opBeq, regPick(), regPick(),
                              16'(off));
        end else begin
            tgt = idx + 2 + int'(randBits(3));
            if (tgt > loopIdx)
                tgt = loopIdx;
            imem[idx] = {kind[0] ? isaPkg::opJal : isaPkg::opJ, 26'(tgt)};
        end
    endtask

    clockGen uClock (.clk(clk), .arstN(arstN));

    mipsCore uut (
        .clk(clk), .arstN(arstN),
        .instAddr(instAddr), .instEn(instEn), .instr(instr),
        .memEn(memEn), .memAddr(memAddr), .memWen(memWen), .memWdata(memWdata),
        .memRdata(memRdata),
        .wbPc(wbPc), .wbWen(wbWen), .wbNum(wbNum), .wbData(wbData)
    );

    refChecker uChecker (
        .clk(clk), .arstN(arstN), .progReady(progReady), .loopPc(32'(loopIdx * 4)),
        .prog(imem), .dmemInit(dmemInit),
        .instEn(instEn), .memEn(memEn),
        .wbPc(wbPc), .wbWen(wbWen), .wbNum(wbNum), .wbData(wbData),
        .memAddr(memAddr), .memWen(memWen), .memWdata(memWdata),
        .done(done), .valueErrors(valueErrors), .otherErrors(otherErrors),
        .pendingWb(pendingWb), .pendingSt(pendingSt)
    );

    assign instr    = imem[instAddr[10:2]];    // both memories answer in the same cycle
    assign memRdata = dmem[memAddr[7:2]];

    always @(posedge clk) begin
        for (int k = 0; k < 4; k++)
            if (memWen[k])
                dmem[memAddr[7:2]][8*k +: 8] <= memWdata[8*k +: 8];
    end

    initial begin
        int idx;
        lfsr = 32'h37c7_3eb0;
        for (idx = 0; idx < 512; idx++)
            imem[idx] = '0;
        for (idx = 0; idx < 64; idx++) begin
            dmemInit[idx] = fillWord(idx);
            dmem[idx]     = dmemInit[idx];
        end
        for (idx = 1; idx < 8; idx++)
            imem[idx - 1] = iType(isaPkg::opOri, 5'd0, 5'(idx), 16'(randBits(16)));
        idx = 7;
        while (idx < loopIdx) begin
            if (idx + 1 < loopIdx && randBits(3) == 32'd0) begin
                genControl(idx);
                genPlain(idx + 1);              // delay slot
                idx += 2;
            end else begin
                genPlain(idx);
                idx++;
            end
        end
        imem[loopIdx] = {isaPkg::opJ, 26'(loopIdx)};
        imem[loopIdx + 1] = rType(5'd0, 5'd0, 5'd0, 5'd0, 6'h3f);  // undefined funct, no write
        progReady = 1'b1;
        wait (done === 1'b1);
        repeat (20) @(posedge clk);             // room for stray retirements
        $display("value errors %0d, other errors %0d", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        #(maxCycles * 8 + 40);
        $display("timeout, %0d register writes and %0d stores never retired",
                 pendingWb, pendingSt);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
